//--- attn_bridge.f
+incdir+.
bridge_data_pkg.sv
bridge_ctrl_pkg.sv
bridge_bank.sv
step_counter.sv
bridge_ctrl_fsm.sv
matmul_array.sv
rshift_stage.sv
attn_bridge.sv
attn_bridge_checker.sv
tb_attn_bridge.sv

//--- attn_bridge.sv
/*
 * Bridge top: Q and K banks, sequencer, step counter, MAC grid, shifter
 */
`include "attn_bridge_defines.svh"

module attn_bridge (
    input  logic                      clk,
    input  logic                      rst_n,
    // Q tile load port
    input  logic                      q_en,
    input  logic                      q_we,
    input  logic [`BR_ADDR_W-1:0]     q_addr,
    input  bridge_data_pkg::q_row_t   q_din,
    // K tile load port
    input  logic                      k_en,
    input  logic                      k_we,
    input  logic [`BR_ADDR_W-1:0]     k_addr,
    input  bridge_data_pkg::k_row_t   k_din,
    // Run control
    input  logic                      start,
    output logic                      busy,
    // Score rows, one per cycle
    output logic                      out_valid,
    output bridge_ctrl_pkg::step_t    out_row_idx,
    output bridge_data_pkg::out_row_t out_row,
    output logic                      out_last
);

    import bridge_data_pkg::*;
    import bridge_ctrl_pkg::*;

    // FSM controls
    logic load_open;
    logic clear_acc;
    logic acc_en;
    logic emit_en;
    logic cnt_clr;
    logic cnt_run;

    // Counter feedback
    step_t step;
    logic  last_step;

    // Broadcast columns and emitted accumulators
    logic [`BR_ROWS*`BR_WIDTH_A-1:0] q_col;
    logic [`BR_ROWS*`BR_WIDTH_B-1:0] k_col;
    acc_row_t                        acc_row;

    bridge_bank #(.payload_t(q_row_t)) q_bank (
        .clk(clk), .rst_n(rst_n),
        .load_open(load_open),
        .en(q_en), .we(q_we), .addr(q_addr), .din(q_din),
        .sel(step),
        .col(q_col)
    );

    bridge_bank #(.payload_t(k_row_t)) k_bank (
        .clk(clk), .rst_n(rst_n),
        .load_open(load_open),
        .en(k_en), .we(k_we), .addr(k_addr), .din(k_din),
        .sel(step),
        .col(k_col)
    );

    bridge_ctrl_fsm u_fsm (
        .clk(clk), .rst_n(rst_n),
        .start(start), .last_step(last_step),
        .busy(busy), .load_open(load_open),
        .clear_acc(clear_acc), .acc_en(acc_en), .emit_en(emit_en),
        .cnt_clr(cnt_clr), .cnt_run(cnt_run)
    );

    step_counter u_cnt (
        .clk(clk), .rst_n(rst_n),
        .clr(cnt_clr), .run(cnt_run),
        .step(step), .last_step(last_step)
    );

    // Step doubles as the emit row select
    matmul_array u_array (
        .clk(clk), .rst_n(rst_n),
        .clear_acc(clear_acc), .acc_en(acc_en),
        .q_col(q_col), .k_col(k_col),
        .row_sel(step),
        .acc_row(acc_row)
    );

    rshift_stage u_rshift (
        .clk(clk), .rst_n(rst_n),
        .in_valid(emit_en), .in_row(acc_row), .in_idx(step),
        .out_valid(out_valid), .out_idx(out_row_idx),
        .out_row(out_row), .out_last(out_last)
    );

endmodule

//--- attn_bridge_checker.sv
/*
 * Concurrent protocol checks for the attention bridge, bound to the top level
 */
module attn_bridge_checker (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   start,
    input logic                   busy,
    input logic                   out_valid,
    input bridge_ctrl_pkg::step_t out_row_idx,
    input logic                   out_last
);

    timeunit 1ns;
    timeprecision 100ps;

    // Start only counts while idle
    logic start_ok;

    assign start_ok = start && !busy;

    // Quiet outputs coming out of reset
    a_reset_quiet: assert property (@(posedge clk) $rose(rst_n) |-> (!busy && !out_valid))
        else $error("busy or out_valid high right after reset");

    a_last_valid: assert property (@(posedge clk) disable iff (!rst_n) out_last |-> out_valid)
        else $error("out_last raised without out_valid");

    // Row 0 exactly 7 cycles after an accepted start
    a_first_row: assert property (@(posedge clk) disable iff (!rst_n)
        $past(start_ok, 7) |-> (out_valid && out_row_idx == '0))
        else $error("first output row missing 7 cycles after start");

    // No burst begins without that start
    a_no_stray_row: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !$past(out_valid)) |-> $past(start_ok, 7))
        else $error("output burst began without a matching start");

    // Rows back to back until the last one
    a_rows_back: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_last) |=> out_valid)
        else $error("gap inside an output burst");

    // Exactly four rows per burst
    a_four_rows: assert property (@(posedge clk) disable iff (!rst_n)
        out_last |-> ($past(out_valid, 1) && $past(out_valid, 2) && $past(out_valid, 3)
                      && !$past(out_valid, 4)))
        else $error("output burst is not four rows long");

    // busy only rises on a start
    a_busy_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(busy) |-> $past(start))
        else $error("busy rose without start");

    // busy only drops together with the last row
    a_busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> out_last)
        else $error("busy fell away from out_last");

    // Run ends 10 cycles after its start
    a_busy_end: assert property (@(posedge clk) disable iff (!rst_n)
        $past(start_ok, 10) |-> (out_last && !busy))
        else $error("run did not end 10 cycles after start");

endmodule

bind attn_bridge attn_bridge_checker u_checker (
    .clk(clk),
    .rst_n(rst_n),
    .start(start),
    .busy(busy),
    .out_valid(out_valid),
    .out_row_idx(out_row_idx),
    .out_last(out_last)
);

//--- attn_bridge_defines.svh
/*
 * Dimension, width and shift macros for the attention bridge
 */
`ifndef ATTN_BRIDGE_DEFINES_SVH
`define ATTN_BRIDGE_DEFINES_SVH

// Rows of Q and K, also rows and columns of the score tile
`define BR_ROWS      4
// Inner dimension, elements per operand row
`define BR_INNER     4
// Row address width for the load ports
`define BR_ADDR_W    2

// Signed operand widths
`define BR_WIDTH_A   8
`define BR_WIDTH_B   8

// Accumulator holds 4 products of 8x8 plus headroom
`define BR_WIDTH_ACC 20

// Output scaling
`define BR_RSHIFT    4
`define BR_WIDTH_OUT 12

`endif

//--- bridge_bank.sv
/*
 * Row-addressed operand bank with column broadcast
 */
`include "attn_bridge_defines.svh"

module bridge_bank #(
    parameter type payload_t = bridge_data_pkg::q_row_t,
    localparam int ELEM_W    = $bits(payload_t) / `BR_INNER
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          load_open,
    input  logic                          en,
    input  logic                          we,
    input  logic [`BR_ADDR_W-1:0]         addr,
    input  payload_t                      din,
    input  bridge_ctrl_pkg::step_t        sel,
    output logic [`BR_ROWS*ELEM_W-1:0]    col
);

    // Stored tile rows
    payload_t rows [`BR_ROWS];

    // Write port, only honored while the controller is idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < `BR_ROWS; r++) begin
                rows[r] <= '0;
            end
        end else if (load_open && en && we) begin
            rows[addr] <= din;
        end
    end

    // Zero-latency read
    // Element sel of every row, row r lands in slot r of col
    always_comb begin
        for (int r = 0; r < `BR_ROWS; r++) begin
            col[r*ELEM_W +: ELEM_W] = rows[r][sel*ELEM_W +: ELEM_W];
        end
    end

endmodule

//--- bridge_ctrl_fsm.sv
/*
 * Sequencer FSM: IDLE, CLEAR, ACCUM, EMIT
 */
module bridge_ctrl_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic last_step,
    output logic busy,
    output logic load_open,
    output logic clear_acc,
    output logic acc_en,
    output logic emit_en,
    output logic cnt_clr,
    output logic cnt_run
);

    import bridge_ctrl_pkg::*;

    bridge_state_t state;
    bridge_state_t state_nxt;

    // State register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Next state and Moore outputs, plus the ACCUM exit clear
    always_comb begin
        state_nxt = state;
        load_open = 1'b0;
        clear_acc = 1'b0;
        acc_en    = 1'b0;
        emit_en   = 1'b0;
        cnt_clr   = 1'b0;
        cnt_run   = 1'b0;

        case (state)
            IDLE: begin
                // Tiles may only be loaded here
                load_open = 1'b1;
                if (start) begin
                    state_nxt = CLEAR;
                end
            end
            CLEAR: begin
                // One cycle, zero the grid and the step count
                clear_acc = 1'b1;
                cnt_clr   = 1'b1;
                state_nxt = ACCUM;
            end
            ACCUM: begin
                acc_en  = 1'b1;
                cnt_run = 1'b1;
                if (last_step) begin
                    // Emit rows start again from row 0
                    cnt_clr   = 1'b1;
                    state_nxt = EMIT;
                end
            end
            EMIT: begin
                emit_en = 1'b1;
                cnt_run = 1'b1;
                if (last_step) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    assign busy = (state != IDLE);

endmodule

//--- bridge_ctrl_pkg.sv
/*
 * Controller types: FSM state and step index
 */
`include "attn_bridge_defines.svh"

package bridge_ctrl_pkg;

    // Sequencer phases
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        CLEAR = 2'd1,
        ACCUM = 2'd2,
        EMIT  = 2'd3
    } bridge_state_t;

    // Inner step during ACCUM, row index during EMIT
    // Both ranges are 0..3 so one width covers them
    typedef logic [`BR_ADDR_W-1:0] step_t;

endpackage

//--- bridge_data_pkg.sv
/*
 * Payload types: operand rows, accumulators, output rows
 */
`include "attn_bridge_defines.svh"

package bridge_data_pkg;

    // One Q row, element 0 in the low bits
    typedef logic [`BR_INNER*`BR_WIDTH_A-1:0] q_row_t;

    // One K row, same packing
    typedef logic [`BR_INNER*`BR_WIDTH_B-1:0] k_row_t;

    // Single signed accumulator
    typedef logic signed [`BR_WIDTH_ACC-1:0] acc_t;

    // One row of accumulators, column 0 low
    typedef logic [`BR_ROWS*`BR_WIDTH_ACC-1:0] acc_row_t;

    // Scaled and saturated score element
    typedef logic signed [`BR_WIDTH_OUT-1:0] out_elem_t;

    // Emitted row of scores, element 0 low
    typedef logic [`BR_ROWS*`BR_WIDTH_OUT-1:0] out_row_t;

endpackage

//--- matmul_array.sv
/*
 * Multiply-accumulate grid for Q times K transpose, with row output mux
 */
`include "attn_bridge_defines.svh"

module matmul_array (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             clear_acc,
    input  logic                             acc_en,
    input  logic [`BR_ROWS*`BR_WIDTH_A-1:0]  q_col,
    input  logic [`BR_ROWS*`BR_WIDTH_B-1:0]  k_col,
    input  bridge_ctrl_pkg::step_t           row_sel,
    output bridge_data_pkg::acc_row_t        acc_row
);

    import bridge_data_pkg::*;

    // Signed operands of the current step
    logic signed [`BR_WIDTH_A-1:0] q_elem [`BR_ROWS];
    logic signed [`BR_WIDTH_B-1:0] k_elem [`BR_ROWS];

    // acc[i][j] is score row i, column j
    acc_t acc [`BR_ROWS][`BR_ROWS];

    genvar i, j;
    generate
        // Unpack the broadcast columns
        for (i = 0; i < `BR_ROWS; i++) begin : g_unpack
            assign q_elem[i] = q_col[i*`BR_WIDTH_A +: `BR_WIDTH_A];
            assign k_elem[i] = k_col[i*`BR_WIDTH_B +: `BR_WIDTH_B];
        end

        for (i = 0; i < `BR_ROWS; i++) begin : g_row
            for (j = 0; j < `BR_ROWS; j++) begin : g_cell
                // Full precision product, sign-extended on the add
                logic signed [`BR_WIDTH_A+`BR_WIDTH_B-1:0] prod;

                assign prod = q_elem[i] * k_elem[j];

                always_ff @(posedge clk or negedge rst_n) begin
                    if (!rst_n) begin
                        acc[i][j] <= '0;
                    end else if (clear_acc) begin
                        acc[i][j] <= '0;
                    end else if (acc_en) begin
                        acc[i][j] <= acc[i][j] + prod;
                    end
                end
            end
        end

        // Row selected for emit, column 0 in the low bits
        for (j = 0; j < `BR_ROWS; j++) begin : g_mux
            assign acc_row[j*`BR_WIDTH_ACC +: `BR_WIDTH_ACC] = acc[row_sel][j];
        end
    endgenerate

endmodule

//--- rshift_stage.sv
/*
 * Registered arithmetic right shift with saturation to the output width
 */
`include "attn_bridge_defines.svh"

module rshift_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  bridge_data_pkg::acc_row_t in_row,
    input  bridge_ctrl_pkg::step_t    in_idx,
    output logic                      out_valid,
    output bridge_ctrl_pkg::step_t    out_idx,
    output bridge_data_pkg::out_row_t out_row,
    output logic                      out_last
);

    import bridge_data_pkg::*;
    import bridge_ctrl_pkg::*;

    // Output range, -2048 to 2047
    localparam acc_t SAT_MAX = acc_t'((1 <<< (`BR_WIDTH_OUT - 1)) - 1);
    localparam acc_t SAT_MIN = acc_t'(-(1 <<< (`BR_WIDTH_OUT - 1)));

    out_row_t row_nxt;

    genvar j;
    generate
        for (j = 0; j < `BR_ROWS; j++) begin : g_elem
            acc_t      elem;
            acc_t      shifted;
            out_elem_t sat;

            assign elem = in_row[j*`BR_WIDTH_ACC +: `BR_WIDTH_ACC];
            // Floor division by 16
            assign shifted = elem >>> `BR_RSHIFT;

            always_comb begin
                if (shifted > SAT_MAX) begin
                    sat = out_elem_t'(SAT_MAX);
                end else if (shifted < SAT_MIN) begin
                    sat = out_elem_t'(SAT_MIN);
                end else begin
                    sat = out_elem_t'(shifted);
                end
            end

            assign row_nxt[j*`BR_WIDTH_OUT +: `BR_WIDTH_OUT] = sat;
        end
    endgenerate

    // Valid and index
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_idx   <= '0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                out_idx <= in_idx;
            end
        end
    end

    // Row data, captured with its valid
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_row <= row_nxt;
        end
    end

    assign out_last = out_valid && (out_idx == step_t'(`BR_ROWS - 1));

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the attention bridge testbench with Verilator, run it, then scan the log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_attn_bridge -f attn_bridge.f -o sim_tb \
    || { echo "compile failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "TEST FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "no pass line in sim.log"; exit 1; }
echo "simulation finished cleanly"
exit 0

//--- step_counter.sv
/*
 * Step counter for the accumulate and emit phases
 */
`include "attn_bridge_defines.svh"

module step_counter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   clr,
    input  logic                   run,
    output bridge_ctrl_pkg::step_t step,
    output logic                   last_step
);

    import bridge_ctrl_pkg::*;

    // Final inner step, also the final emit row
    localparam step_t STEP_LAST = step_t'(`BR_INNER - 1);

    // Clear wins over run
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step <= '0;
        end else if (clr) begin
            step <= '0;
        end else if (run) begin
            // Wraps back to 0 after the final step
            step <= step + 1'b1;
        end
    end

    // Seen by the FSM in the same cycle as the last step
    assign last_step = (step == STEP_LAST);

endmodule

//--- tb_attn_bridge.sv
/*
 * Testbench for the attention bridge: stimulus, score model, row checks,
 * watchdog and summary
 */
`include "attn_bridge_defines.svh"

module tb_attn_bridge;

    timeunit 1ns;
    timeprecision 100ps;

    import bridge_data_pkg::*;
    import bridge_ctrl_pkg::*;

    localparam int NUM_TESTS   = 9;
    localparam int WATCHDOG_NS = (NUM_TESTS * 40 + 200) * 10;
    localparam int ROW_WAIT    = 30;
    localparam int OUT_MAX     = 2 ** (`BR_WIDTH_OUT - 1) - 1;
    localparam int OUT_MIN     = -(2 ** (`BR_WIDTH_OUT - 1));

    logic                  clk;
    logic                  rst_n;
    logic                  q_en;
    logic                  q_we;
    logic [`BR_ADDR_W-1:0] q_addr;
    q_row_t                q_din;
    logic                  k_en;
    logic                  k_we;
    logic [`BR_ADDR_W-1:0] k_addr;
    k_row_t                k_din;
    logic                  start;
    logic                  busy;
    logic                  out_valid;
    step_t                 out_row_idx;
    out_row_t              out_row;
    logic                  out_last;

    // Tiles the DUT should hold, and the tiles about to be written
    logic signed [`BR_WIDTH_A-1:0] q_mem  [`BR_ROWS][`BR_INNER];
    logic signed [`BR_WIDTH_B-1:0] k_mem  [`BR_ROWS][`BR_INNER];
    logic signed [`BR_WIDTH_A-1:0] q_next [`BR_ROWS][`BR_INNER];
    logic signed [`BR_WIDTH_B-1:0] k_next [`BR_ROWS][`BR_INNER];

    out_row_t exp_rows [`BR_ROWS];
    int       rows_total;
    int       run_base;
    int       errors;
    int       tests_run;
    int       tests_failed;
    bit       summary_done;

    attn_bridge i_attn_bridge (
        .clk(clk), .rst_n(rst_n),
        .q_en(q_en), .q_we(q_we), .q_addr(q_addr), .q_din(q_din),
        .k_en(k_en), .k_we(k_we), .k_addr(k_addr), .k_din(k_din),
        .start(start), .busy(busy),
        .out_valid(out_valid), .out_row_idx(out_row_idx),
        .out_row(out_row), .out_last(out_last)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Dot product over the inner dimension, floor shift, clamp to 12 bits
    function automatic out_elem_t score(input int i, input int j);
        int sum;
        int scaled;
        sum = 0;
        for (int k = 0; k < `BR_INNER; k++) begin
            sum += int'(q_mem[i][k]) * int'(k_mem[j][k]);
        end
        scaled = sum >>> `BR_RSHIFT;
        if (scaled > OUT_MAX) begin
            scaled = OUT_MAX;
        end else if (scaled < OUT_MIN) begin
            scaled = OUT_MIN;
        end
        return out_elem_t'(scaled);
    endfunction

    // Both ports write one row per cycle
    // Dropped writes leave the model tiles alone
    task automatic load_tiles(input bit honored);
        for (int r = 0; r < `BR_ROWS; r++) begin
            #1;
            if (!honored) begin
                assert (busy) else begin
                    $display("write meant to be dropped was issued while idle");
                    errors++;
                end
            end
            q_en   = 1'b1;
            q_we   = 1'b1;
            k_en   = 1'b1;
            k_we   = 1'b1;
            q_addr = r[`BR_ADDR_W-1:0];
            k_addr = r[`BR_ADDR_W-1:0];
            for (int k = 0; k < `BR_INNER; k++) begin
                q_din[k*`BR_WIDTH_A +: `BR_WIDTH_A] = q_next[r][k];
                k_din[k*`BR_WIDTH_B +: `BR_WIDTH_B] = k_next[r][k];
            end
            @(posedge clk);
        end
        #1;
        q_en = 1'b0;
        q_we = 1'b0;
        k_en = 1'b0;
        k_we = 1'b0;
        if (honored) begin
            q_mem = q_next;
            k_mem = k_next;
        end
        @(posedge clk);
    endtask

    task automatic pulse_start();
        #1;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    // Expected rows come from the model tiles at start time
    task automatic start_run();
        for (int i = 0; i < `BR_ROWS; i++) begin
            for (int j = 0; j < `BR_ROWS; j++) begin
                exp_rows[i][j*`BR_WIDTH_OUT +: `BR_WIDTH_OUT] = score(i, j);
            end
        end
        run_base = rows_total;
        pulse_start();
    endtask

    task automatic wait_rows();
        int cycles;
        cycles = 0;
        while (rows_total - run_base < `BR_ROWS && cycles < ROW_WAIT) begin
            @(posedge clk);
            cycles++;
        end
        assert (rows_total - run_base == `BR_ROWS) else begin
            $display("run gave %0d of %0d rows in time", rows_total - run_base, `BR_ROWS);
            errors++;
        end
    endtask

    task automatic fill_random();
        logic [31:0] rnd;
        for (int r = 0; r < `BR_ROWS; r++) begin
            for (int k = 0; k < `BR_INNER; k++) begin
                rnd          = $urandom;
                q_next[r][k] = rnd[`BR_WIDTH_A-1:0];
                k_next[r][k] = rnd[16 +: `BR_WIDTH_B];
            end
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
        end
    endtask

    // Output rows sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        int idx;
        if (rst_n && out_valid) begin
            idx = rows_total - run_base;
            if (idx >= `BR_ROWS) begin
                $display("extra output row beyond the four of a run");
                errors++;
            end else begin
                assert (out_row_idx == step_t'(idx)) else begin
                    $display("error: out_row_idx got %h expected %h", out_row_idx, idx);
                    errors++;
                end
                assert (out_row == exp_rows[idx]) else begin
                    $display("error: out_row row %0d got %h expected %h",
                             idx, out_row, exp_rows[idx]);
                    errors++;
                end
                assert (out_last == (idx == `BR_ROWS - 1)) else begin
                    $display("error: out_last got %h expected %h",
                             out_last, idx == `BR_ROWS - 1);
                    errors++;
                end
            end
            rows_total++;
        end
    end

    initial begin
        int err_mark;
        int v;
        void'($urandom(32'h8a5c_279d));
        rst_n        = 1'b0;
        q_en         = 1'b0;
        q_we         = 1'b0;
        q_addr       = '0;
        q_din        = '0;
        k_en         = 1'b0;
        k_we         = 1'b0;
        k_addr       = '0;
        k_din        = '0;
        start        = 1'b0;
        rows_total   = 0;
        run_base     = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        summary_done = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);

        // Diagonal K of 16 so the shifted scores equal Q
        err_mark = errors;
        for (int r = 0; r < `BR_ROWS; r++) begin
            for (int k = 0; k < `BR_INNER; k++) begin
                v            = r * `BR_INNER + k - 7;
                q_next[r][k] = v[`BR_WIDTH_A-1:0];
                k_next[r][k] = (r == k) ? 8'h10 : 8'h00;
            end
        end
        load_tiles(1'b1);
        start_run();
        wait_rows();
        report_test("identity tiles", err_mark);

        for (int n = 0; n < 5; n++) begin
            err_mark = errors;
            fill_random();
            load_tiles(1'b1);
            start_run();
            wait_rows();
            report_test("random tiles", err_mark);
        end

        // Alternating rows of 127 and -128 reach both clamp limits
        err_mark = errors;
        for (int r = 0; r < `BR_ROWS; r++) begin
            for (int k = 0; k < `BR_INNER; k++) begin
                q_next[r][k] = r[0] ? 8'h80 : 8'h7f;
                k_next[r][k] = (r < 2) ? 8'h7f : 8'h80;
            end
        end
        load_tiles(1'b1);
        start_run();
        wait_rows();
        report_test("saturation", err_mark);

        // New rows written mid-run are dropped until loaded again in IDLE
        err_mark = errors;
        fill_random();
        start_run();
        @(posedge clk);
        load_tiles(1'b0);
        wait_rows();
        start_run();
        wait_rows();
        load_tiles(1'b1);
        start_run();
        wait_rows();
        report_test("writes during busy", err_mark);

        // Second start lands in ACCUM, then back to back runs
        err_mark = errors;
        fill_random();
        load_tiles(1'b1);
        start_run();
        repeat (2) @(posedge clk);
        pulse_start();
        wait_rows();
        repeat (12) @(posedge clk);
        assert (rows_total - run_base == `BR_ROWS && !busy) else begin
            $display("start during a run was not ignored");
            errors++;
        end
        start_run();
        wait_rows();
        start_run();
        wait_rows();
        report_test("start while busy", err_mark);

        summary_done = 1'b1;
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Watchdog sized from the test count
    initial begin
        #(WATCHDOG_NS);
        summary_done = 1'b1;
        $display("watchdog expired after %0d ns", WATCHDOG_NS);
        $display("TEST FAIL");
        $finish;
    end

    // Run stopped before the summary, e.g. by a failed protocol assertion
    final begin
        if (!summary_done) begin
            $display("TEST FAIL");
        end
    end

endmodule
